// File: common/axi_mem_config.svh
// AXI memory configuration
// Bus widths, memory depth and the simulation timeout margin

`ifndef AXI_MEM_CONFIG_SVH
`define AXI_MEM_CONFIG_SVH

`define AXI_MEM_ADDR_W 16
`define AXI_MEM_DATA_W 32
`define AXI_MEM_ID_W 4
`define AXI_MEM_STRB_W (`AXI_MEM_DATA_W / 8)

// Number of words held by the array
`define AXI_MEM_DEPTH 256

// Extra cycles allowed on top of the expected run length
`define AXI_MEM_TIMEOUT_MARGIN 200

`endif

// File: common/axi_burst_pkg.sv
// AXI burst types
// Burst kind, response code and beat count as seen on the AXI channels

package axi_burst_pkg;

  // WRAP and the reserved code both fall back to FIXED behaviour
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Number of beats in a burst minus one
  typedef logic [7:0] len_t;

endpackage

// File: common/mem_pipe_pkg.sv
// Memory pipeline types
// Front FSM states and the opcode carried by each beat

package mem_pipe_pkg;

  typedef enum logic [1:0] {
    IDLE        = 2'b00,
    WRITE_BURST = 2'b01,
    READ_BURST  = 2'b10,
    WAIT_RESP   = 2'b11
  } front_state_e;

  typedef enum logic {
    BEAT_WRITE = 1'b0,
    BEAT_READ  = 1'b1
  } beat_op_e;

endpackage

// File: common/mem_beat_if.sv
// Memory beat link
// One beat with valid/ready handshake between two pipeline stages

`timescale 1ns/1ps
`include "axi_mem_config.svh"

interface mem_beat_if
  import mem_pipe_pkg::*;
();

  logic                        valid;
  logic                        ready;
  beat_op_e                    op;
  logic [`AXI_MEM_ADDR_W-1:0]  addr;
  logic [`AXI_MEM_DATA_W-1:0]  data;
  logic [`AXI_MEM_STRB_W-1:0]  strb;
  logic [`AXI_MEM_ID_W-1:0]    id;
  logic                        last;

  modport source (output valid, op, addr, data, strb, id, last, input ready);
  modport sink (input valid, op, addr, data, strb, id, last, output ready);

endinterface

// File: axi_mem/axi_mem_front.sv
// AXI memory front stage
// Accepts one write or read burst at a time and issues one beat command
// per cycle, with the beat address worked out for FIXED and INCR bursts

`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_mem_front
  import axi_burst_pkg::*;
  import mem_pipe_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        aw_valid_i,
  input  logic [`AXI_MEM_ID_W-1:0]    aw_id_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  aw_addr_i,
  input  len_t                        aw_len_i,
  input  logic [1:0]                  aw_burst_i,
  input  logic                        w_valid_i,
  input  logic [`AXI_MEM_DATA_W-1:0]  w_data_i,
  input  logic [`AXI_MEM_STRB_W-1:0]  w_strb_i,
  input  logic                        w_last_i,
  input  logic                        ar_valid_i,
  input  logic [`AXI_MEM_ID_W-1:0]    ar_id_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  ar_addr_i,
  input  len_t                        ar_len_i,
  input  logic [1:0]                  ar_burst_i,
  output logic                        aw_ready_o,
  output logic                        w_ready_o,
  output logic                        ar_ready_o,
  input  logic                        burst_done_i,
  mem_beat_if.source                  cmd
);

  localparam logic [`AXI_MEM_ADDR_W-1:0] ADDR_STEP = `AXI_MEM_ADDR_W'(`AXI_MEM_STRB_W);

  front_state_e               state_q;
  front_state_e               state_d;
  logic [`AXI_MEM_ID_W-1:0]   id_q;
  logic [`AXI_MEM_ADDR_W-1:0] addr_q;
  len_t                       len_q;
  len_t                       cnt_q;
  burst_e                     burst_q;
  logic                       aw_hs;
  logic                       ar_hs;
  logic                       beat_hs;
  logic                       beat_last;

  // Writes win when AW and AR arrive together
  // Address readies stay low while reset is held
  assign aw_ready_o = rst_n_i && (state_q == IDLE);
  assign ar_ready_o = rst_n_i && (state_q == IDLE) && !aw_valid_i;
  assign w_ready_o  = (state_q == WRITE_BURST) && cmd.ready;

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign ar_hs = ar_valid_i && ar_ready_o;

  assign beat_last = (cnt_q == len_q);
  assign beat_hs   = cmd.valid && cmd.ready;

  // W beats pass straight through, read beats need no input
  assign cmd.valid = ((state_q == WRITE_BURST) && w_valid_i) || (state_q == READ_BURST);
  assign cmd.op    = (state_q == WRITE_BURST) ? BEAT_WRITE : BEAT_READ;
  assign cmd.addr  = addr_q;
  assign cmd.data  = w_data_i;
  assign cmd.strb  = (state_q == WRITE_BURST) ? w_strb_i : '0;
  assign cmd.id    = id_q;
  assign cmd.last  = beat_last;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (aw_hs) begin
          state_d = WRITE_BURST;
        end else if (ar_hs) begin
          state_d = READ_BURST;
        end
      end
      WRITE_BURST, READ_BURST: begin
        if (beat_hs && beat_last) begin
          state_d = WAIT_RESP;
        end
      end
      WAIT_RESP: begin
        if (burst_done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (aw_hs || ar_hs) begin
        cnt_q <= '0;
      end else if (beat_hs) begin
        cnt_q <= cnt_q + 8'd1;
      end
    end
  end

  // Burst descriptor, loaded on acceptance
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q    <= aw_id_i;
      addr_q  <= aw_addr_i;
      len_q   <= aw_len_i;
      burst_q <= (aw_burst_i == BURST_INCR) ? BURST_INCR : BURST_FIXED;
    end else if (ar_hs) begin
      id_q    <= ar_id_i;
      addr_q  <= ar_addr_i;
      len_q   <= ar_len_i;
      burst_q <= (ar_burst_i == BURST_INCR) ? BURST_INCR : BURST_FIXED;
    end else if (beat_hs && (burst_q == BURST_INCR)) begin
      addr_q <= addr_q + ADDR_STEP;
    end
  end

endmodule

// File: axi_mem/axi_mem_array.sv
// AXI memory array stage
// Word storage with byte-strobed writes and registered reads; beats
// outside the depth are flagged, dropped on write and read as zero

`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_mem_array
  import mem_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  mem_beat_if.sink   cmd,
  mem_beat_if.source done,
  output logic       err_o
);

  localparam int IDX_W = $clog2(`AXI_MEM_DEPTH);
  localparam int OFS_W = $clog2(`AXI_MEM_STRB_W);
  localparam logic [`AXI_MEM_ADDR_W-1:0] ADDR_LIMIT =
    `AXI_MEM_ADDR_W'(`AXI_MEM_DEPTH * `AXI_MEM_STRB_W);

  logic [`AXI_MEM_DATA_W-1:0] mem_q [`AXI_MEM_DEPTH];
  logic [IDX_W-1:0]           idx;
  logic                       in_range;
  logic                       cmd_hs;
  logic                       valid_q;
  beat_op_e                   op_q;
  logic [`AXI_MEM_ADDR_W-1:0] addr_q;
  logic [`AXI_MEM_DATA_W-1:0] data_q;
  logic [`AXI_MEM_STRB_W-1:0] strb_q;
  logic [`AXI_MEM_ID_W-1:0]   id_q;
  logic                       last_q;
  logic                       err_q;

  assign idx      = cmd.addr[OFS_W +: IDX_W];
  assign in_range = (cmd.addr < ADDR_LIMIT);

  // One beat may wait here while the next one is accepted
  assign cmd.ready = !valid_q || done.ready;
  assign cmd_hs    = cmd.valid && cmd.ready;

  always_ff @(posedge clk_i) begin
    if (cmd_hs && (cmd.op == BEAT_WRITE) && in_range) begin
      for (int b = 0; b < `AXI_MEM_STRB_W; b++) begin
        if (cmd.strb[b]) begin
          mem_q[idx][b*8 +: 8] <= cmd.data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (cmd_hs) begin
      valid_q <= 1'b1;
    end else if (done.ready) begin
      valid_q <= 1'b0;
    end
  end

  // Write beats carry their own data on for the monitor
  always_ff @(posedge clk_i) begin
    if (cmd_hs) begin
      op_q   <= cmd.op;
      addr_q <= cmd.addr;
      strb_q <= cmd.strb;
      id_q   <= cmd.id;
      last_q <= cmd.last;
      err_q  <= !in_range;
      if (cmd.op == BEAT_WRITE) begin
        data_q <= cmd.data;
      end else begin
        data_q <= in_range ? mem_q[idx] : '0;
      end
    end
  end

  assign done.valid = valid_q;
  assign done.op    = op_q;
  assign done.addr  = addr_q;
  assign done.data  = data_q;
  assign done.strb  = strb_q;
  assign done.id    = id_q;
  assign done.last  = last_q;
  assign err_o      = err_q;

endmodule

// File: axi_mem/axi_mem_resp.sv
// AXI memory response stage
// Turns finished beats into R beats and B responses, and registers
// every accepted beat onto the monitor outputs

`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_mem_resp
  import axi_burst_pkg::*;
  import mem_pipe_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  mem_beat_if.sink                    done,
  input  logic                        err_i,
  output logic                        b_valid_o,
  output logic [`AXI_MEM_ID_W-1:0]    b_id_o,
  output resp_e                       b_resp_o,
  output logic                        r_valid_o,
  output logic [`AXI_MEM_ID_W-1:0]    r_id_o,
  output logic [`AXI_MEM_DATA_W-1:0]  r_data_o,
  output resp_e                       r_resp_o,
  output logic                        r_last_o,
  input  logic                        b_ready_i,
  input  logic                        r_ready_i,
  output logic                        burst_done_o,
  output logic                        mon_valid_o,
  output logic                        mon_we_o,
  output logic [`AXI_MEM_ADDR_W-1:0]  mon_addr_o,
  output logic [`AXI_MEM_DATA_W-1:0]  mon_data_o,
  output logic [`AXI_MEM_ID_W-1:0]    mon_id_o,
  output logic                        mon_last_o
);

  logic beat_read;
  logic done_hs;
  logic b_load;
  logic err_acc_q;

  assign beat_read = (done.op == BEAT_READ);

  // The last write beat waits while an earlier B is still held
  assign done.ready = beat_read ? r_ready_i : (!done.last || !b_valid_o);
  assign done_hs    = done.valid && done.ready;
  assign b_load     = done_hs && !beat_read && done.last;

  assign r_valid_o = done.valid && beat_read;
  assign r_id_o    = done.id;
  assign r_data_o  = done.data;
  assign r_resp_o  = err_i ? RESP_SLVERR : RESP_OKAY;
  assign r_last_o  = done.last;

  assign burst_done_o = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i && done.last);

  // Error seen on any earlier beat of the current write burst
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_acc_q <= 1'b0;
      b_valid_o <= 1'b0;
    end else begin
      if (done_hs && !beat_read) begin
        err_acc_q <= done.last ? 1'b0 : (err_acc_q || err_i);
      end
      if (b_load) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_load) begin
      b_id_o   <= done.id;
      b_resp_o <= (err_acc_q || err_i) ? RESP_SLVERR : RESP_OKAY;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mon_valid_o <= 1'b0;
    end else begin
      mon_valid_o <= done_hs;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done_hs) begin
      mon_we_o   <= !beat_read;
      mon_addr_o <= done.addr;
      mon_data_o <= done.data;
      mon_id_o   <= done.id;
      mon_last_o <= done.last;
    end
  end

endmodule

// File: rtl/axi_mem_top.sv
// AXI4 memory subordinate
// Front, array and response stages in a pipeline, with a beat monitor

`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_mem_top
  import axi_burst_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`AXI_MEM_ID_W-1:0]    aw_id_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  aw_addr_i,
  input  len_t                        aw_len_i,
  input  logic [1:0]                  aw_burst_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  logic [`AXI_MEM_DATA_W-1:0]  w_data_i,
  input  logic [`AXI_MEM_STRB_W-1:0]  w_strb_i,
  input  logic                        w_last_i,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output logic [`AXI_MEM_ID_W-1:0]    b_id_o,
  output logic [1:0]                  b_resp_o,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  logic [`AXI_MEM_ID_W-1:0]    ar_id_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  ar_addr_i,
  input  len_t                        ar_len_i,
  input  logic [1:0]                  ar_burst_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output logic [`AXI_MEM_ID_W-1:0]    r_id_o,
  output logic [`AXI_MEM_DATA_W-1:0]  r_data_o,
  output logic [1:0]                  r_resp_o,
  output logic                        r_last_o,
  output logic                        mon_valid_o,
  output logic                        mon_we_o,
  output logic [`AXI_MEM_ADDR_W-1:0]  mon_addr_o,
  output logic [`AXI_MEM_DATA_W-1:0]  mon_data_o,
  output logic [`AXI_MEM_ID_W-1:0]    mon_id_o,
  output logic                        mon_last_o
);

  logic burst_done;
  logic done_err;

  mem_beat_if cmd ();
  mem_beat_if done ();

  axi_mem_front u_front (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .aw_valid_i   (aw_valid_i),
    .aw_id_i      (aw_id_i),
    .aw_addr_i    (aw_addr_i),
    .aw_len_i     (aw_len_i),
    .aw_burst_i   (aw_burst_i),
    .w_valid_i    (w_valid_i),
    .w_data_i     (w_data_i),
    .w_strb_i     (w_strb_i),
    .w_last_i     (w_last_i),
    .ar_valid_i   (ar_valid_i),
    .ar_id_i      (ar_id_i),
    .ar_addr_i    (ar_addr_i),
    .ar_len_i     (ar_len_i),
    .ar_burst_i   (ar_burst_i),
    .aw_ready_o   (aw_ready_o),
    .w_ready_o    (w_ready_o),
    .ar_ready_o   (ar_ready_o),
    .burst_done_i (burst_done),
    .cmd          (cmd.source)
  );

  axi_mem_array u_array (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cmd     (cmd.sink),
    .done    (done.source),
    .err_o   (done_err)
  );

  axi_mem_resp u_resp (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .done         (done.sink),
    .err_i        (done_err),
    .b_valid_o    (b_valid_o),
    .b_id_o       (b_id_o),
    .b_resp_o     (b_resp_o),
    .r_valid_o    (r_valid_o),
    .r_id_o       (r_id_o),
    .r_data_o     (r_data_o),
    .r_resp_o     (r_resp_o),
    .r_last_o     (r_last_o),
    .b_ready_i    (b_ready_i),
    .r_ready_i    (r_ready_i),
    .burst_done_o (burst_done),
    .mon_valid_o  (mon_valid_o),
    .mon_we_o     (mon_we_o),
    .mon_addr_o   (mon_addr_o),
    .mon_data_o   (mon_data_o),
    .mon_id_o     (mon_id_o),
    .mon_last_o   (mon_last_o)
  );

endmodule

// File: verif/axi_mem_assert.sv
// AXI memory assertions
// Reset state of the handshake outputs, W last position and payload
// stability under stall

`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_mem_assert (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        aw_ready_o,
  input logic                        ar_ready_o,
  input logic                        w_valid_i,
  input logic                        w_ready_o,
  input logic                        w_last_i,
  input logic                        beat_last_i,
  input logic                        b_valid_o,
  input logic                        b_ready_i,
  input logic [`AXI_MEM_ID_W-1:0]    b_id_o,
  input logic [1:0]                  b_resp_o,
  input logic                        r_valid_o,
  input logic                        r_ready_i,
  input logic [`AXI_MEM_ID_W-1:0]    r_id_o,
  input logic [`AXI_MEM_DATA_W-1:0]  r_data_o,
  input logic [1:0]                  r_resp_o,
  input logic                        r_last_o,
  input logic                        mon_valid_o
);

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !aw_ready_o && !w_ready_o && !ar_ready_o && !b_valid_o && !r_valid_o
      && !mon_valid_o)
    else $error("Ready or valid active during reset");

  // The beat count decides last, W last must agree with it
  w_last_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_valid_i && w_ready_o |-> (w_last_i == beat_last_i))
    else $error("W last does not match the burst length");

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o) && $stable(b_resp_o))
    else $error("B payload changed while stalled");

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_id_o) && $stable(r_data_o)
      && $stable(r_resp_o) && $stable(r_last_o))
    else $error("R payload changed while stalled");

endmodule

// File: verif/axi_mem_checker.sv
// AXI memory checker
// Compares B, R and monitor beats against the expected queues filled
// by the driver, in order

`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_mem_checker (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        b_valid_i,
  input logic                        b_ready_i,
  input logic [`AXI_MEM_ID_W-1:0]    b_id_i,
  input logic [1:0]                  b_resp_i,
  input logic                        r_valid_i,
  input logic                        r_ready_i,
  input logic [`AXI_MEM_ID_W-1:0]    r_id_i,
  input logic [`AXI_MEM_DATA_W-1:0]  r_data_i,
  input logic [1:0]                  r_resp_i,
  input logic                        r_last_i,
  input logic                        mon_valid_i,
  input logic                        mon_we_i,
  input logic [`AXI_MEM_ADDR_W-1:0]  mon_addr_i,
  input logic [`AXI_MEM_DATA_W-1:0]  mon_data_i,
  input logic [`AXI_MEM_ID_W-1:0]    mon_id_i,
  input logic                        mon_last_i
);

  string test_name = "none";
  int    err_count = 0;
  int    check_count = 0;

  // Expected beats, each field in its own queue
  logic [31:0] b_q[$];
  logic [31:0] r_q[$];
  logic [31:0] m_q[$];
  logic [31:0] r_data_q[$];
  logic [31:0] m_addr_q[$];
  logic [31:0] m_data_q[$];

  function void set_test(input string name);
    test_name = name;
  endfunction

  // Small fields are packed as id, resp and last flags
  function void expect_b(input logic [3:0] id, input logic [1:0] resp);
    b_q.push_back({26'd0, id, resp});
  endfunction

  function void expect_r(input logic [3:0] id, input logic [31:0] data,
                         input logic [1:0] resp, input logic last);
    r_q.push_back({25'd0, id, resp, last});
    r_data_q.push_back(data);
  endfunction

  function void expect_mon(input logic we, input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] id, input logic last);
    m_q.push_back({26'd0, id, we, last});
    m_addr_q.push_back({16'd0, addr});
    m_data_q.push_back(data);
  endfunction

  function int pending();
    return b_q.size() + r_q.size() + m_q.size();
  endfunction

  function void compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endfunction

  // Sampled mid-cycle where all handshake signals are settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (b_valid_i && b_ready_i) begin
        if (b_q.size() == 0) begin
          err_count++;
          $display("%s: B response arrived with none expected", test_name);
        end else begin
          compare("b id/resp", b_q.pop_front(), {26'd0, b_id_i, b_resp_i});
        end
      end
      if (r_valid_i && r_ready_i) begin
        if (r_q.size() == 0) begin
          err_count++;
          $display("%s: R beat arrived with none expected", test_name);
        end else begin
          compare("r id/resp/last", r_q.pop_front(), {25'd0, r_id_i, r_resp_i, r_last_i});
          compare("r data", r_data_q.pop_front(), r_data_i);
        end
      end
      if (mon_valid_i) begin
        if (m_q.size() == 0) begin
          err_count++;
          $display("%s: monitor reported a beat that was never issued", test_name);
        end else begin
          compare("mon id/we/last", m_q.pop_front(), {26'd0, mon_id_i, mon_we_i, mon_last_i});
          compare("mon addr", m_addr_q.pop_front(), {16'd0, mon_addr_i});
          compare("mon data", m_data_q.pop_front(), mon_data_i);
        end
      end
    end
  end

endmodule

// File: verif/axi_mem_tb.sv
// AXI memory testbench
// Drives write and read bursts into the DUT, keeps a byte model of the
// memory and hands the expected responses to the checker

`timescale 1ns/1ps
`include "axi_mem_config.svh"

module axi_mem_tb
  import axi_burst_pkg::*;
;

  logic                        clk_i;
  logic                        rst_n_i;
  logic                        aw_valid_i;
  logic                        aw_ready_o;
  logic [`AXI_MEM_ID_W-1:0]    aw_id_i;
  logic [`AXI_MEM_ADDR_W-1:0]  aw_addr_i;
  logic [7:0]                  aw_len_i;
  logic [1:0]                  aw_burst_i;
  logic                        w_valid_i;
  logic                        w_ready_o;
  logic [`AXI_MEM_DATA_W-1:0]  w_data_i;
  logic [`AXI_MEM_STRB_W-1:0]  w_strb_i;
  logic                        w_last_i;
  logic                        b_valid_o;
  logic                        b_ready_i;
  logic [`AXI_MEM_ID_W-1:0]    b_id_o;
  logic [1:0]                  b_resp_o;
  logic                        ar_valid_i;
  logic                        ar_ready_o;
  logic [`AXI_MEM_ID_W-1:0]    ar_id_i;
  logic [`AXI_MEM_ADDR_W-1:0]  ar_addr_i;
  logic [7:0]                  ar_len_i;
  logic [1:0]                  ar_burst_i;
  logic                        r_valid_o;
  logic                        r_ready_i;
  logic [`AXI_MEM_ID_W-1:0]    r_id_o;
  logic [`AXI_MEM_DATA_W-1:0]  r_data_o;
  logic [1:0]                  r_resp_o;
  logic                        r_last_o;
  logic                        mon_valid_o;
  logic                        mon_we_o;
  logic [`AXI_MEM_ADDR_W-1:0]  mon_addr_o;
  logic [`AXI_MEM_DATA_W-1:0]  mon_data_o;
  logic [`AXI_MEM_ID_W-1:0]    mon_id_o;
  logic                        mon_last_o;

  // Byte model of the memory
  logic [7:0] ref_mem [`AXI_MEM_DEPTH*4];
  integer     seed;
  int         total_beats;
  int         cycles;
  logic       stall_en;
  logic [31:0] rnd;

  axi_mem_top dut (.*);

  axi_mem_checker u_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .b_valid_i   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .b_id_i      (b_id_o),
    .b_resp_i    (b_resp_o),
    .r_valid_i   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_id_i      (r_id_o),
    .r_data_i    (r_data_o),
    .r_resp_i    (r_resp_o),
    .r_last_i    (r_last_o),
    .mon_valid_i (mon_valid_o),
    .mon_we_i    (mon_we_o),
    .mon_addr_i  (mon_addr_o),
    .mon_data_i  (mon_data_o),
    .mon_id_i    (mon_id_o),
    .mon_last_i  (mon_last_o)
  );

  always #20 clk_i = ~clk_i;

  // Applies a beat to the model and returns the word at its address
  function automatic logic [31:0] ref_beat(input logic is_write, input logic [15:0] addr,
                                           input logic [31:0] data, input logic [3:0] strb,
                                           output logic [1:0] resp);
    int base;
    logic [31:0] word;
    base = int'({addr[15:2], 2'b00});
    if (int'(addr) >= `AXI_MEM_DEPTH * 4) begin
      resp = RESP_SLVERR;
      return 32'h0;
    end
    resp = RESP_OKAY;
    for (int b = 0; b < 4; b++) begin
      if (is_write && strb[b]) begin
        ref_mem[base+b] = data[b*8 +: 8];
      end
      word[b*8 +: 8] = ref_mem[base+b];
    end
    return word;
  endfunction

  // Channel 0 is AW, 1 is W, 2 is AR; ready is sampled away from the edge
  task automatic complete_handshake(input int ch);
    logic hs;
    do begin
      @(negedge clk_i);
      hs = (ch == 0) ? aw_ready_o : (ch == 1) ? w_ready_o : ar_ready_o;
      @(posedge clk_i);
    end while (!hs);
    #2;
  endtask

  task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                             input logic [7:0] len, input logic [1:0] burst,
                             input logic full_strb);
    logic [15:0] beat_addr;
    logic [1:0]  resp;
    logic [1:0]  acc;
    total_beats += int'(len) + 3;
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_len_i   = len;
    aw_burst_i = burst;
    complete_handshake(0);
    aw_valid_i = 1'b0;
    beat_addr  = addr;
    acc        = RESP_OKAY;
    for (int i = 0; i <= int'(len); i++) begin
      rnd       = $random(seed);
      w_data_i  = rnd;
      rnd       = $random(seed);
      w_strb_i  = full_strb ? 4'hf : rnd[3:0];
      w_last_i  = (i == int'(len));
      w_valid_i = 1'b1;
      complete_handshake(1);
      void'(ref_beat(1'b1, beat_addr, w_data_i, w_strb_i, resp));
      if (resp == RESP_SLVERR) begin
        acc = RESP_SLVERR;
      end
      u_chk.expect_mon(1'b1, beat_addr, w_data_i, id, i == int'(len));
      if (burst == BURST_INCR) begin
        beat_addr = beat_addr + 16'd4;
      end
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    u_chk.expect_b(id, acc);
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [15:0] addr,
                            input logic [7:0] len, input logic [1:0] burst);
    logic [15:0] beat_addr;
    logic [1:0]  resp;
    logic [31:0] word;
    total_beats += int'(len) + 4;
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = addr;
    ar_len_i   = len;
    ar_burst_i = burst;
    complete_handshake(2);
    ar_valid_i = 1'b0;
    beat_addr  = addr;
    for (int i = 0; i <= int'(len); i++) begin
      word = ref_beat(1'b0, beat_addr, 32'h0, 4'h0, resp);
      u_chk.expect_r(id, word, resp, i == int'(len));
      u_chk.expect_mon(1'b0, beat_addr, word, id, i == int'(len));
      if (burst == BURST_INCR) begin
        beat_addr = beat_addr + 16'd4;
      end
    end
  endtask

  // Random back-pressure on R and B while stalling is enabled
  always @(posedge clk_i) begin
    #2;
    if (stall_en) begin
      r_ready_i = ($random(seed) & 3) != 0;
      b_ready_i = ($random(seed) & 3) != 0;
    end else begin
      r_ready_i = 1'b1;
      b_ready_i = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > total_beats * 4 + `AXI_MEM_TIMEOUT_MARGIN) begin
      $display("Timeout: the run did not finish after %0d cycles", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    logic [15:0] addr;
    logic [7:0]  len;
    logic [3:0]  id;
    seed = 33;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    stall_en = 1'b0;
    total_beats = 0;
    cycles = 0;
    aw_valid_i = 1'b0;
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    aw_burst_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    ar_burst_i = '0;
    r_ready_i = 1'b1;
    b_ready_i = 1'b1;
    for (int i = 0; i < `AXI_MEM_DEPTH * 4; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    u_chk.set_test("single_beat");
    write_burst(4'd1, 16'h0010, 8'd0, BURST_INCR, 1'b1);
    read_burst(4'd1, 16'h0010, 8'd0, BURST_INCR);

    u_chk.set_test("incr_burst");
    repeat (3) begin
      rnd  = $random(seed);
      addr = {7'd0, rnd[6:0], 2'b00};
      len  = {4'd0, rnd[11:8]};
      id   = rnd[15:12];
      write_burst(id, addr, len, BURST_INCR, 1'b1);
      read_burst(~id, addr, len, BURST_INCR);
    end

    u_chk.set_test("fixed_burst");
    write_burst(4'd3, 16'h0200, 8'd0, BURST_INCR, 1'b1);
    write_burst(4'd4, 16'h0200, 8'd3, BURST_FIXED, 1'b0);
    read_burst(4'd5, 16'h0200, 8'd1, BURST_FIXED);

    u_chk.set_test("partial_strobe");
    write_burst(4'd6, 16'h0300, 8'd0, BURST_INCR, 1'b1);
    repeat (4) begin
      write_burst(4'd7, 16'h0300, 8'd0, BURST_INCR, 1'b0);
      read_burst(4'd8, 16'h0300, 8'd0, BURST_INCR);
    end

    // Out-of-range beats alias onto the lowest words if they are not dropped
    u_chk.set_test("out_of_range");
    write_burst(4'd12, 16'h0000, 8'd3, BURST_INCR, 1'b1);
    write_burst(4'd9, 16'h03e8, 8'd9, BURST_INCR, 1'b1);
    read_burst(4'd10, 16'h03e8, 8'd9, BURST_INCR);
    write_burst(4'd11, 16'h0800, 8'd0, BURST_FIXED, 1'b1);
    read_burst(4'd13, 16'h0000, 8'd3, BURST_INCR);

    u_chk.set_test("back_pressure");
    stall_en = 1'b1;
    repeat (6) begin
      rnd  = $random(seed);
      addr = {6'd0, rnd[7:0] % 8'd240, 2'b00};
      len  = {5'd0, rnd[10:8]};
      id   = rnd[15:12];
      write_burst(id, addr, len, BURST_INCR, 1'b1);
      read_burst(id, addr, len, BURST_INCR);
    end

    while (u_chk.pending() != 0) begin
      @(posedge clk_i);
    end
    stall_en = 1'b0;
    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", u_chk.check_count, u_chk.err_count);
    if (u_chk.err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

bind axi_mem_top axi_mem_assert u_assert (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .aw_ready_o  (aw_ready_o),
  .ar_ready_o  (ar_ready_o),
  .w_valid_i   (w_valid_i),
  .w_ready_o   (w_ready_o),
  .w_last_i    (w_last_i),
  .beat_last_i (cmd.last),
  .b_valid_o   (b_valid_o),
  .b_ready_i   (b_ready_i),
  .b_id_o      (b_id_o),
  .b_resp_o    (b_resp_o),
  .r_valid_o   (r_valid_o),
  .r_ready_i   (r_ready_i),
  .r_id_o      (r_id_o),
  .r_data_o    (r_data_o),
  .r_resp_o    (r_resp_o),
  .r_last_o    (r_last_o),
  .mon_valid_o (mon_valid_o)
);

// File: build.f
+incdir+common
common/axi_burst_pkg.sv
common/mem_pipe_pkg.sv
common/mem_beat_if.sv
axi_mem/axi_mem_front.sv
axi_mem/axi_mem_array.sv
axi_mem/axi_mem_resp.sv
rtl/axi_mem_top.sv
verif/axi_mem_assert.sv
verif/axi_mem_checker.sv
verif/axi_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the AXI memory simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module axi_mem_tb -o axi_mem_sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/axi_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0
